// File: video_pkg.sv
package video_pkg;

    // ******************************
    // geometry
    // ******************************
    localparam int color_depth = 8;     // bits per channel
    localparam int x_bits      = 8;
    localparam int y_bits      = 8;
    localparam int line_len    = 64;    // active pixels per line
    localparam int n_tiles     = 5;

    localparam logic [x_bits-1:0] tile_w  = 8'd12;
    localparam logic [y_bits-1:0] tile_h  = 8'd12;
    localparam logic [y_bits-1:0] tile_y0 = 8'd2;    // single tile row

    // start columns, index 0 is the leftmost tile
    localparam logic [n_tiles-1:0][x_bits-1:0] tile_x0 = {8'd50, 8'd38, 8'd26, 8'd14, 8'd2};

    // ******************************
    // pixel processing
    // ******************************
    localparam logic [color_depth-1:0] bin_threshold = 8'd128;

    // weights sum to 256
    localparam logic [color_depth-1:0] luma_kr = 8'd77;
    localparam logic [color_depth-1:0] luma_kg = 8'd150;
    localparam logic [color_depth-1:0] luma_kb = 8'd29;

    // cycles after the input sample edge
    localparam int lat_luma  = 2;
    localparam int lat_bin   = 3;
    localparam int lat_morph = 5;
    localparam int lat_total = 6;

    typedef struct packed {
        logic [color_depth-1:0] r;
        logic [color_depth-1:0] g;
        logic [color_depth-1:0] b;
    } rgb_t;

    localparam rgb_t back_color = rgb_t'(24'hE0FFFF);   // light cyan

    typedef struct packed {
        logic vs;
        logic hs;
        logic de;
    } sync_t;

    // travels alongside the pixel path
    typedef struct packed {
        sync_t             sync;
        logic [x_bits-1:0] x;
        logic [y_bits-1:0] y;
    } raster_t;

    // bit 0 of each row is the newest column
    typedef struct packed {
        logic [2:0] top;    // row y-2
        logic [2:0] mid;    // row y-1
        logic [2:0] bot;    // row y
    } window_t;

    typedef enum logic [2:0] {
        view_orig,
        view_grey,
        view_bin,
        view_dil,
        view_ero,
        view_back
    } view_e;

endpackage

// File: stage_delay.sv
module stage_delay #(
    parameter int depth = 2,
    parameter int width = 8
) (
    input  logic             pix_clk,
    input  logic             rstn,
    input  logic [width-1:0] data_in,
    output logic [width-1:0] data_out
);

    logic [depth-1:0][width-1:0] pipe;   // pipe[0] is the newest

    always_ff @(posedge pix_clk or negedge rstn) begin
        if (!rstn) begin
            pipe <= '0;
        end else begin
            pipe[0] <= data_in;
            for (int i = 1; i < depth; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign data_out = pipe[depth-1];

endmodule

// File: luma_binarize.sv
module luma_binarize (
    input  logic                              pix_clk,
    input  logic                              rstn,
    input  video_pkg::rgb_t                   rgb_in,
    output logic [video_pkg::color_depth-1:0] grey,
    output logic                              bin
);

    logic [2*video_pkg::color_depth-1:0] prod_r;
    logic [2*video_pkg::color_depth-1:0] prod_g;
    logic [2*video_pkg::color_depth-1:0] prod_b;
    logic [2*video_pkg::color_depth-1:0] luma_sum;

    // weights add up to 256, so the sum never overflows 16 bits
    assign luma_sum = prod_r + prod_g + prod_b;

    always_ff @(posedge pix_clk or negedge rstn) begin
        if (!rstn) begin
            prod_r <= '0;
            prod_g <= '0;
            prod_b <= '0;
        end else begin
            prod_r <= rgb_in.r * video_pkg::luma_kr;   // stage 1
            prod_g <= rgb_in.g * video_pkg::luma_kg;
            prod_b <= rgb_in.b * video_pkg::luma_kb;
        end
    end

    always_ff @(posedge pix_clk or negedge rstn) begin
        if (!rstn) begin
            grey <= '0;
            bin  <= 1'b0;
        end else begin
            // divide by 256
            grey <= luma_sum[2*video_pkg::color_depth-1:video_pkg::color_depth];
            bin  <= grey > video_pkg::bin_threshold;   // stage 3, strictly above
        end
    end

endmodule

// File: morph_3x3.sv
module morph_3x3 (
    input  logic               pix_clk,
    input  logic               rstn,
    input  logic               bin_in,
    input  video_pkg::raster_t raster,
    output logic               dil,
    output logic               ero
);

    logic [video_pkg::line_len-1:0] line_1;   // previous line
    logic [video_pkg::line_len-1:0] line_2;   // line before that
    logic                           tap_1;
    logic                           tap_2;
    video_pkg::window_t             win;

    // oldest bit of each buffer sits in the same column one line up
    assign tap_1 = line_1[video_pkg::line_len-1];
    assign tap_2 = line_2[video_pkg::line_len-1];

    // ******************************
    // line buffers
    // ******************************
    always_ff @(posedge pix_clk) begin
        if (raster.sync.vs) begin
            line_1 <= '0;     // rows above row 0 read as black
            line_2 <= '0;
        end else if (raster.sync.de) begin
            line_1 <= {line_1[video_pkg::line_len-2:0], bin_in};
            line_2 <= {line_2[video_pkg::line_len-2:0], tap_1};
        end
    end

    // ******************************
    // 3x3 window
    // ******************************
    always_ff @(posedge pix_clk or negedge rstn) begin
        if (!rstn) begin
            win <= '0;
        end else if (raster.sync.vs || !raster.sync.de) begin
            win <= '0;        // columns left of x=0 read as black
        end else begin
            win.bot <= {win.bot[1:0], bin_in};
            win.mid <= {win.mid[1:0], tap_1};
            win.top <= {win.top[1:0], tap_2};
        end
    end

    // result belongs to the newest pixel, no re-centring
    always_ff @(posedge pix_clk or negedge rstn) begin
        if (!rstn) begin
            dil <= 1'b0;
            ero <= 1'b0;
        end else begin
            dil <= |win;
            ero <= &win;
        end
    end

endmodule

// File: tile_compositor.sv
module tile_compositor (
    input  logic                              pix_clk,
    input  logic                              rstn,
    input  video_pkg::raster_t                raster,
    input  video_pkg::rgb_t                   orig,
    input  logic [video_pkg::color_depth-1:0] grey,
    input  logic                              bin,
    input  logic                              dil,
    input  logic                              ero,
    output video_pkg::sync_t                  sync_out,
    output video_pkg::rgb_t                   pixel_data
);

    video_pkg::view_e view;
    video_pkg::rgb_t  color;
    logic             in_row;

    assign in_row = (raster.y >= video_pkg::tile_y0)
                 && (raster.y < video_pkg::tile_y0 + video_pkg::tile_h);

    // ******************************
    // tile decode
    // ******************************
    always_comb begin
        view = video_pkg::view_back;
        if (raster.sync.de && in_row) begin
            for (int k = 0; k < video_pkg::n_tiles; k++) begin
                if ((raster.x >= video_pkg::tile_x0[k])
                        && (raster.x < video_pkg::tile_x0[k] + video_pkg::tile_w)) begin
                    view = video_pkg::view_e'(3'(k));   // tile order matches the enum
                end
            end
        end
    end

    // binary views go to full white or black
    always_comb begin
        case (view)
            video_pkg::view_orig: color = orig;
            video_pkg::view_grey: color = '{r: grey, g: grey, b: grey};
            video_pkg::view_bin:  color = {3*video_pkg::color_depth{bin}};
            video_pkg::view_dil:  color = {3*video_pkg::color_depth{dil}};
            video_pkg::view_ero:  color = {3*video_pkg::color_depth{ero}};
            default:              color = video_pkg::back_color;
        endcase
    end

    // ******************************
    // output register
    // ******************************
    always_ff @(posedge pix_clk or negedge rstn) begin
        if (!rstn) begin
            sync_out   <= '0;
            pixel_data <= video_pkg::back_color;
        end else begin
            sync_out   <= raster.sync;
            pixel_data <= color;
        end
    end

endmodule

// File: video_display.sv
module video_display (
    input  logic                         pix_clk,
    input  logic                         rstn,
    input  logic [video_pkg::x_bits-1:0] act_x,
    input  logic [video_pkg::y_bits-1:0] act_y,
    input  logic                         vs_in,
    input  logic                         hs_in,
    input  logic                         de_in,
    input  video_pkg::rgb_t              rgb_in,
    output logic                         vs_out,
    output logic                         hs_out,
    output logic                         de_out,
    output video_pkg::rgb_t              pixel_data
);

    video_pkg::raster_t                raster_in;
    video_pkg::raster_t                raster_bin;   // aligned with bin
    video_pkg::raster_t                raster_mix;   // aligned with morph results
    video_pkg::rgb_t                   rgb_mix;
    logic [video_pkg::color_depth-1:0] grey;
    logic [video_pkg::color_depth-1:0] grey_mix;
    logic                              bin;
    logic                              bin_mix;
    logic                              dil;
    logic                              ero;
    video_pkg::sync_t                  sync_out;

    assign raster_in = '{sync: '{vs: vs_in, hs: hs_in, de: de_in}, x: act_x, y: act_y};

    // ******************************
    // processing chain
    // ******************************
    luma_binarize u_luma_binarize (
        .pix_clk (pix_clk),
        .rstn    (rstn),
        .rgb_in  (rgb_in),
        .grey    (grey),     // cycle 2
        .bin     (bin)       // cycle 3
    );

    stage_delay #(.depth(video_pkg::lat_bin), .width($bits(video_pkg::raster_t))) u_raster_bin (
        .pix_clk  (pix_clk),
        .rstn     (rstn),
        .data_in  (raster_in),
        .data_out (raster_bin)
    );

    morph_3x3 u_morph_3x3 (
        .pix_clk (pix_clk),
        .rstn    (rstn),
        .bin_in  (bin),
        .raster  (raster_bin),
        .dil     (dil),      // cycle 5
        .ero     (ero)
    );

    // ******************************
    // align every branch to cycle 5
    // ******************************
    stage_delay #(.depth(video_pkg::lat_morph), .width($bits(video_pkg::rgb_t))) u_rgb_delay (
        .pix_clk  (pix_clk),
        .rstn     (rstn),
        .data_in  (rgb_in),
        .data_out (rgb_mix)
    );

    stage_delay #(
        .depth (video_pkg::lat_morph - video_pkg::lat_luma),
        .width (video_pkg::color_depth)
    ) u_grey_delay (
        .pix_clk  (pix_clk),
        .rstn     (rstn),
        .data_in  (grey),
        .data_out (grey_mix)
    );

    stage_delay #(.depth(video_pkg::lat_morph - video_pkg::lat_bin), .width(1)) u_bin_delay (
        .pix_clk  (pix_clk),
        .rstn     (rstn),
        .data_in  (bin),
        .data_out (bin_mix)
    );

    stage_delay #(
        .depth (video_pkg::lat_morph - video_pkg::lat_bin),
        .width ($bits(video_pkg::raster_t))
    ) u_raster_mix (
        .pix_clk  (pix_clk),
        .rstn     (rstn),
        .data_in  (raster_bin),
        .data_out (raster_mix)
    );

    tile_compositor u_tile_compositor (
        .pix_clk    (pix_clk),
        .rstn       (rstn),
        .raster     (raster_mix),
        .orig       (rgb_mix),
        .grey       (grey_mix),
        .bin        (bin_mix),
        .dil        (dil),
        .ero        (ero),
        .sync_out   (sync_out),
        .pixel_data (pixel_data)  // cycle 6
    );

    assign vs_out = sync_out.vs;
    assign hs_out = sync_out.hs;
    assign de_out = sync_out.de;

endmodule

// File: tb_clock_gen.sv
module tb_clock_gen (
    output logic pix_clk,
    output logic rstn
);

    localparam int half_period = 50;
    localparam int reset_edges = 4;

    initial begin
        pix_clk = 1'b0;
        forever #half_period pix_clk = ~pix_clk;
    end

    // released on the fourth rising edge, after the DUT has sampled it low
    initial begin
        rstn = 1'b0;
        repeat (reset_edges) @(posedge pix_clk);
        rstn <= 1'b1;
    end

endmodule

// File: video_display_sva.sv
module video_display_sva (
    input logic            pix_clk,
    input logic            rstn,
    input logic            vs_in,
    input logic            hs_in,
    input logic            de_in,
    input logic            vs_out,
    input logic            hs_out,
    input logic            de_out,
    input video_pkg::rgb_t pixel_data
);

    int unsigned settled;   // edges since reset release

    always_ff @(posedge pix_clk or negedge rstn) begin
        if (!rstn) begin
            settled <= 0;
        end else if (settled < video_pkg::lat_total) begin
            settled <= settled + 1;
        end
    end

    // ******************************
    // output checks
    // ******************************
    sync_delay_a: assert property (@(posedge pix_clk) disable iff (!rstn)
        settled >= video_pkg::lat_total |->
            {vs_out, hs_out, de_out} == $past({vs_in, hs_in, de_in}, video_pkg::lat_total))
        else $error("output syncs differ from the input syncs of %0d cycles before",
                    video_pkg::lat_total);

    blank_back_a: assert property (@(posedge pix_clk) disable iff (!rstn)
        !de_out |-> pixel_data == video_pkg::back_color)
        else $error("pixel with de_out low is not the background colour");

    known_out_a: assert property (@(posedge pix_clk) disable iff (!rstn)
        !$isunknown({vs_out, hs_out, de_out, pixel_data}))
        else $error("unknown value on the video outputs");

endmodule

bind video_display video_display_sva i_video_display_sva (
    .pix_clk    (pix_clk),
    .rstn       (rstn),
    .vs_in      (vs_in),
    .hs_in      (hs_in),
    .de_in      (de_in),
    .vs_out     (vs_out),
    .hs_out     (hs_out),
    .de_out     (de_out),
    .pixel_data (pixel_data)
);

// File: tb_video_display.sv
module tb_video_display;

    localparam int frame_h  = 16;
    localparam int h_total  = 72;     // 64 active pixels plus blanking
    localparam int hs_start = 66;
    localparam int hs_stop  = 70;
    localparam int wait_max = 200;    // edges

    typedef struct packed {
        logic [7:0]      x;
        logic [7:0]      y;
        video_pkg::rgb_t rgb;
    } pix_rec_t;

    logic                         pix_clk;
    logic                         rstn;
    logic [video_pkg::x_bits-1:0] act_x;
    logic [video_pkg::y_bits-1:0] act_y;
    logic                         vs_in;
    logic                         hs_in;
    logic                         de_in;
    video_pkg::rgb_t              rgb_in;
    logic                         vs_out;
    logic                         hs_out;
    logic                         de_out;
    video_pkg::rgb_t              pixel_data;

    video_pkg::rgb_t    img     [frame_h][video_pkg::line_len];   // input frame
    video_pkg::rgb_t    out_img [frame_h][video_pkg::line_len];   // captured output
    video_pkg::raster_t hist    [video_pkg::lat_total];
    pix_rec_t           expect_q[$];
    string              test_name = "reset";
    int                 captured;
    int                 error_count;
    int                 check_count;

    tb_clock_gen u_clock_gen (
        .pix_clk (pix_clk),
        .rstn    (rstn)
    );

    video_display i_video_display (.*);

    task automatic check_value(input string name, input logic [23:0] expected,
                               input logic [23:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic require_fields(input int got, input int want, input string kind);
        if (got != want) begin
            error_count++;
            $display("malformed %s record in video_tests.txt", kind);
        end
    endtask

    // ******************************
    // output capture
    // ******************************
    always @(negedge pix_clk) begin
        video_pkg::raster_t pos;
        pos = hist[video_pkg::lat_total-1];   // inputs seen six falling edges ago
        check_value($sformatf("%s sync", test_name), 24'(pos.sync),
                    {21'b0, vs_out, hs_out, de_out});
        if (!pos.sync.de) begin
            check_value($sformatf("%s blank", test_name), video_pkg::back_color, pixel_data);
        end else if (pos.y < frame_h && pos.x < video_pkg::line_len) begin
            out_img[pos.y][pos.x] = pixel_data;
            captured++;
        end
        for (int i = video_pkg::lat_total - 1; i > 0; i--) begin
            hist[i] = hist[i-1];
        end
        hist[0] = '{sync: '{vs: vs_in, hs: hs_in, de: de_in}, x: act_x, y: act_y};
    end

    task automatic drive_line(input logic vs, input int y, input logic active);
        for (int x = 0; x < h_total; x++) begin
            @(posedge pix_clk);
            vs_in <= vs;
            hs_in <= (x >= hs_start) && (x < hs_stop);
            de_in <= active && (x < video_pkg::line_len);
            act_x <= 8'(x);
            act_y <= 8'(y);
            if (active && x < video_pkg::line_len) begin
                rgb_in <= img[y][x];
            end else begin
                rgb_in <= '0;
            end
        end
    endtask

    // one vs line, then the active frame, then the expected pixels
    task automatic run_frame();
        int waited;
        foreach (out_img[i, j]) begin
            out_img[i][j] = 'x;
        end
        captured = 0;
        drive_line(1'b1, 0, 1'b0);
        for (int y = 0; y < frame_h; y++) begin
            drive_line(1'b0, y, 1'b1);
        end
        waited = 0;
        while (captured < frame_h * video_pkg::line_len && waited < wait_max) begin
            @(posedge pix_clk);
            waited++;
        end
        if (captured < frame_h * video_pkg::line_len) begin
            error_count++;
            $display("timeout in %s: only %0d output pixels arrived", test_name, captured);
        end
        foreach (expect_q[i]) begin
            check_value($sformatf("%s (%0d,%0d)", test_name, expect_q[i].x, expect_q[i].y),
                        expect_q[i].rgb, out_img[expect_q[i].y][expect_q[i].x]);
        end
    endtask

    initial begin
        int               fd;
        int               n;
        int               x;
        int               y;
        int               w;
        int               h;
        int               waited;
        logic [8*16-1:0]  kw;
        logic [8*32-1:0]  name_bits;
        logic [8*128-1:0] rest;
        video_pkg::rgb_t  color;
        pix_rec_t         rec;

        act_x  = '0;
        act_y  = '0;
        vs_in  = 1'b0;
        hs_in  = 1'b0;
        de_in  = 1'b0;
        rgb_in = '0;
        foreach (hist[i]) begin
            hist[i] = '0;
        end
        error_count = 0;
        check_count = 0;

        waited = 0;
        while (rstn !== 1'b1 && waited < wait_max) begin
            @(posedge pix_clk);
            waited++;
        end
        if (rstn !== 1'b1) begin
            error_count++;
            $display("reset was never released");
        end

        fd = $fopen("video_tests.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("could not open video_tests.txt");
        end else begin
            while ($fscanf(fd, "%s", kw) == 1) begin
                case (kw)
                    "#":    n = $fgets(rest, fd);
                    "test": begin
                        n = $fscanf(fd, "%s %h", name_bits, color);
                        require_fields(n, 2, "test");
                        test_name = $sformatf("%0s", name_bits);
                        foreach (img[i, j]) begin
                            img[i][j] = color;
                        end
                        expect_q.delete();
                    end
                    "pix": begin
                        n = $fscanf(fd, "%d %d %h", x, y, color);
                        require_fields(n, 3, "pix");
                        img[y][x] = color;
                    end
                    "box": begin
                        n = $fscanf(fd, "%d %d %d %d %h", x, y, w, h, color);
                        require_fields(n, 5, "box");
                        for (int i = y; i < y + h; i++) begin
                            for (int j = x; j < x + w; j++) begin
                                img[i][j] = color;
                            end
                        end
                    end
                    "exp": begin
                        n = $fscanf(fd, "%d %d %h", x, y, color);
                        require_fields(n, 3, "exp");
                        rec.x   = 8'(x);
                        rec.y   = 8'(y);
                        rec.rgb = color;
                        expect_q.push_back(rec);
                    end
                    "end":  run_frame();
                    default: begin
                        error_count++;
                        $display("unknown record in video_tests.txt");
                        n = $fgets(rest, fd);
                    end
                endcase
            end
            $fclose(fd);
        end

        $display("%0d errors in %0d checks", error_count, check_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: video_tests.txt
# test <name> <fill rgb>, then pix <x> <y> <rgb> or box <x> <y> <w> <h> <rgb> set input pixels
# exp <x> <y> <rgb> is an expected output pixel, end runs the frame; rgb values in hex
test reset_back 000000
exp 0 0 e0ffff
exp 63 15 e0ffff
exp 1 5 e0ffff
exp 62 5 e0ffff
exp 5 1 e0ffff
exp 5 14 e0ffff
exp 5 5 000000
end
test orig_grey 000000
pix 5 3 123456
pix 13 13 a5c3e7
pix 20 6 ff8040
pix 14 2 ffffff
pix 25 13 102030
exp 5 3 123456
exp 13 13 a5c3e7
exp 20 6 9e9e9e
exp 14 2 ffffff
exp 25 13 1d1d1d
exp 15 2 000000
end
test threshold 000000
pix 30 7 808080
pix 31 7 818181
exp 30 7 000000
exp 31 7 ffffff
exp 32 7 000000
end
test isolated 000000
pix 40 5 ffffff
pix 55 8 ffffff
exp 40 5 ffffff
exp 41 6 ffffff
exp 42 7 ffffff
exp 39 5 000000
exp 43 5 000000
exp 40 4 000000
exp 40 8 000000
exp 55 8 000000
exp 57 10 000000
end
test block_erode 000000
box 52 4 5 5 ffffff
exp 54 6 ffffff
exp 55 7 ffffff
exp 56 8 ffffff
exp 53 6 000000
exp 57 8 000000
exp 54 5 000000
exp 56 9 000000
end

// File: files.f
video_pkg.sv
stage_delay.sv
luma_binarize.sv
morph_3x3.sv
tile_compositor.sv
video_display.sv
tb_clock_gen.sv
video_display_sva.sv
tb_video_display.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_video_display \
    -f files.f -o tb_video_display
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_video_display)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
